//--- hw/dining_table.sv
`timescale 1ns/1ns

module dining_table #(
  parameter int N_PHILO    = dpp_pkg::DEF_N_PHILO,
  parameter int EAT_TIME   = dpp_pkg::DEF_EAT_TIME,
  parameter int THINK_TIME = dpp_pkg::DEF_THINK_TIME,
  parameter int FIFO_DEPTH = dpp_pkg::DEF_FIFO_DEPTH
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [N_PHILO-1:0]  hunger,
  input  logic                log_ready,
  output logic [N_PHILO-1:0]  hungry,
  output logic [N_PHILO-1:0]  eating,
  output logic                log_valid,
  output dpp_pkg::grant_rec_t log_rec
);

  import dpp_pkg::*;

  logic [N_PHILO-1:0] may_eat;
  logic [N_PHILO-1:0] evt_push;
  philo_evt_e         evt_in   [N_PHILO];  // philosopher to its queue
  logic [N_PHILO-1:0] evt_pop;
  philo_evt_e         evt_head [N_PHILO];  // queue head to arbiter
  logic [N_PHILO-1:0] evt_empty;

  logic               log_push;
  grant_rec_t         log_push_rec;
  logic               log_empty;
  logic               log_full;

  // one seat per philosopher, each with its own event queue
  for (genvar i = 0; i < N_PHILO; i++) begin : g_seat
    philosopher #(
      .EAT_TIME   (EAT_TIME),
      .THINK_TIME (THINK_TIME)
    ) philo_i (
      .clk      (clk),
      .reset    (reset),
      .hunger   (hunger[i]),
      .may_eat  (may_eat[i]),
      .hungry   (hungry[i]),
      .eating   (eating[i]),
      .evt_push (evt_push[i]),
      .evt_data (evt_in[i])
    );

    event_fifo #(
      .payload_t (philo_evt_e),
      .DEPTH     (FIFO_DEPTH)
    ) evt_q_i (
      .clk       (clk),
      .reset     (reset),
      .push      (evt_push[i]),
      .push_data (evt_in[i]),
      .pop       (evt_pop[i]),
      .pop_data  (evt_head[i]),
      .empty     (evt_empty[i]),
      .full      ()  // a philosopher never outruns its queue
    );
  end

  fork_arbiter #(
    .N_PHILO (N_PHILO)
  ) arbiter_i (
    .clk       (clk),
    .reset     (reset),
    .evt_empty (evt_empty),
    .evt_data  (evt_head),
    .hungry    (hungry),
    .log_full  (log_full),
    .evt_pop   (evt_pop),
    .may_eat   (may_eat),
    .log_push  (log_push),
    .log_rec   (log_push_rec)
  );

  event_fifo #(
    .payload_t (grant_rec_t),
    .DEPTH     (FIFO_DEPTH)
  ) grant_log_i (
    .clk       (clk),
    .reset     (reset),
    .push      (log_push),
    .push_data (log_push_rec),
    .pop       (log_ready),  // reader side handshake
    .pop_data  (log_rec),
    .empty     (log_empty),
    .full      (log_full)
  );

  assign log_valid = ~log_empty;

endmodule

//--- hw/dpp_pkg.sv
package dpp_pkg;

  // events a philosopher reports to the arbiter
  typedef enum logic {
    PHILO_HUNGRY = 1'b0,
    PHILO_DONE   = 1'b1
  } philo_evt_e;

  // state of one fork on the table
  typedef enum logic {
    FORK_AVAIL = 1'b0,
    FORK_TAKEN = 1'b1
  } fork_e;

  localparam int PHILO_ID_W = 4;  // enough for 16 seats
  localparam int SEQ_W      = 8;  // grant counter wraps at 256

  // one entry of the grant log, 12 bits
  typedef struct packed {
    logic [PHILO_ID_W-1:0] philo_id;  // who was granted
    logic [SEQ_W-1:0]      seq;       // running grant count
  } grant_rec_t;

  // defaults for the top level parameters
  localparam int DEF_N_PHILO    = 4;  // at most 16
  localparam int DEF_EAT_TIME   = 3;  // cycles spent eating
  localparam int DEF_THINK_TIME = 4;  // minimum thinking cycles
  localparam int DEF_FIFO_DEPTH = 4;  // entries per queue

endpackage

//--- hw/event_fifo.sv
`timescale 1ns/1ns

module event_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push & ~full;   // writes into a full queue are dropped
  assign do_pop  = pop & ~empty;

  assign pop_data = mem[rd_ptr];   // head is visible without a read cycle

  // storage, written at the tail
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

//--- hw/fork_arbiter.sv
`timescale 1ns/1ns

module fork_arbiter #(
  parameter int N_PHILO = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [N_PHILO-1:0]  evt_empty,
  input  dpp_pkg::philo_evt_e evt_data [N_PHILO],
  input  logic [N_PHILO-1:0]  hungry,
  input  logic                log_full,
  output logic [N_PHILO-1:0]  evt_pop,
  output logic [N_PHILO-1:0]  may_eat,
  output logic                log_push,
  output dpp_pkg::grant_rec_t log_rec
);

  import dpp_pkg::*;

  localparam int IDX_W = (N_PHILO > 1) ? $clog2(N_PHILO) : 1;

  fork_e              forks [N_PHILO];  // fork n sits left of philosopher n
  logic [N_PHILO-1:0] granted;          // holds both forks, DONE not yet seen
  logic [IDX_W-1:0]   last_idx;         // last queue served
  logic [SEQ_W-1:0]   seq;

  logic               stall;
  logic               take;
  logic [IDX_W-1:0]   sel_idx;
  logic [IDX_W-1:0]   sel_rfork;
  logic               grant_en;
  logic [IDX_W-1:0]   grant_idx;
  logic [IDX_W-1:0]   grant_rfork;

  // a push issued this cycle is not yet counted in log_full
  assign stall = log_full | log_push;

  // round robin, first nonempty queue after the last one served
  always_comb begin
    int idx;
    take    = 1'b0;
    sel_idx = last_idx;
    for (int k = 1; k <= N_PHILO; k++) begin
      idx = (int'(last_idx) + k) % N_PHILO;
      if (!stall && !take && !evt_empty[idx]) begin
        take    = 1'b1;
        sel_idx = IDX_W'(idx);
      end
    end
  end

  always_comb begin
    evt_pop = '0;
    if (take) begin
      evt_pop[sel_idx] = 1'b1;
    end
  end

  // grant decision for the event at the head of the selected queue
  always_comb begin
    int n;
    int r;
    int l;
    int r_far;
    n           = int'(sel_idx);
    r           = (n + 1) % N_PHILO;            // right neighbour, shares fork r
    l           = (n + N_PHILO - 1) % N_PHILO;  // left neighbour, shares fork n
    r_far       = (n + 2) % N_PHILO;            // right neighbour's other fork
    sel_rfork   = IDX_W'(r);
    grant_en    = 1'b0;
    grant_idx   = sel_idx;
    grant_rfork = IDX_W'(r);
    if (take) begin
      if (evt_data[n] == PHILO_HUNGRY) begin
        // stale HUNGRY after a hand-over is skipped through granted
        if (!granted[n] && forks[n] == FORK_AVAIL && forks[r] == FORK_AVAIL) begin
          grant_en = 1'b1;
        end
      end else if (hungry[r] && !granted[r] && forks[r_far] == FORK_AVAIL) begin
        grant_en    = 1'b1;
        grant_idx   = IDX_W'(r);
        grant_rfork = IDX_W'(r_far);
      end else if (hungry[l] && !granted[l] && forks[l] == FORK_AVAIL) begin
        grant_en    = 1'b1;
        grant_idx   = IDX_W'(l);
        grant_rfork = IDX_W'(n);
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < N_PHILO; i++) begin
        forks[i] <= FORK_AVAIL;
      end
      granted  <= '0;
      may_eat  <= '0;
      log_push <= 1'b0;
      last_idx <= IDX_W'(N_PHILO - 1);  // queue 0 is served first
      seq      <= '0;
    end else begin
      may_eat  <= '0;
      log_push <= 1'b0;
      if (take) begin
        last_idx <= sel_idx;
        if (evt_data[sel_idx] == PHILO_DONE) begin
          forks[sel_idx]   <= FORK_AVAIL;
          forks[sel_rfork] <= FORK_AVAIL;
          granted[sel_idx] <= 1'b0;
        end
      end
      if (grant_en) begin
        // later assignment wins over the release above on a hand-over
        forks[grant_idx]   <= FORK_TAKEN;
        forks[grant_rfork] <= FORK_TAKEN;
        granted[grant_idx] <= 1'b1;
        may_eat[grant_idx] <= 1'b1;
        log_push           <= 1'b1;
        seq                <= seq + 1'b1;  // wraps
      end
    end
  end

  // log payload, valid only with log_push
  always_ff @(posedge clk) begin
    if (grant_en) begin
      log_rec.philo_id <= PHILO_ID_W'(grant_idx);
      log_rec.seq      <= seq;
    end
  end

endmodule

//--- hw/philosopher.sv
`timescale 1ns/1ns

module philosopher #(
  parameter int EAT_TIME   = 3,
  parameter int THINK_TIME = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                hunger,
  input  logic                may_eat,
  output logic                hungry,
  output logic                eating,
  output logic                evt_push,
  output dpp_pkg::philo_evt_e evt_data
);

  import dpp_pkg::*;

  localparam int TMAX  = (EAT_TIME > THINK_TIME) ? EAT_TIME : THINK_TIME;
  localparam int TMR_W = (TMAX > 0) ? $clog2(TMAX + 1) : 1;

  typedef enum logic [1:0] {
    ST_THINK,
    ST_HUNGRY,
    ST_EAT
  } state_e;

  state_e           state;
  logic [TMR_W-1:0] timer;  // eat or think countdown

  assign hungry = (state == ST_HUNGRY);
  assign eating = (state == ST_EAT);

  // a push only ever happens in the first cycle of hungry or of thinking,
  // so the event kind follows from the current state
  assign evt_data = (state == ST_HUNGRY) ? PHILO_HUNGRY : PHILO_DONE;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ST_THINK;
      timer    <= '0;  // expired, hunger accepted at once
      evt_push <= 1'b0;
    end else begin
      evt_push <= 1'b0;
      case (state)
        ST_THINK: begin
          if (timer != '0) begin
            timer <= timer - 1'b1;  // hunger ignored while counting
          end else if (hunger) begin
            state    <= ST_HUNGRY;
            evt_push <= 1'b1;       // HUNGRY
          end
        end
        ST_HUNGRY: begin
          if (may_eat) begin
            state <= ST_EAT;
            timer <= TMR_W'(EAT_TIME);
          end
        end
        ST_EAT: begin
          if (timer <= TMR_W'(1)) begin
            // last eating cycle, back to thinking and report DONE
            state    <= ST_THINK;
            timer    <= TMR_W'(THINK_TIME);
            evt_push <= 1'b1;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        default: begin
          state <= ST_THINK;
          timer <= '0;
        end
      endcase
    end
  end

endmodule

//--- project.f
hw/dpp_pkg.sv
hw/event_fifo.sv
hw/philosopher.sv
hw/fork_arbiter.sv
hw/dining_table.sv
tb/table_sva.sv
tb/table_checker.sv
tb/tb_dining_table.sv

//--- tb/table_checker.sv
`timescale 1ns/1ns

module table_checker #(
  parameter int N_PHILO    = 4,
  parameter int EAT_TIME   = 3,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [N_PHILO-1:0]  hungry,
  input  logic [N_PHILO-1:0]  eating,
  input  logic                log_valid,
  input  logic                log_ready,
  input  dpp_pkg::grant_rec_t log_rec,
  input  logic                arm_progress,
  input  logic                report_starve,
  output int                  errors,
  output int                  pending,
  output logic                all_ate
);

  import dpp_pkg::*;

  logic [N_PHILO-1:0] hungry_q;    // values at the previous edge
  logic [N_PHILO-1:0] eating_q;
  logic [N_PHILO-1:0] fork_taken;  // fork model, built from eating edges
  logic [N_PHILO-1:0] ate;         // ate since the progress window opened
  int                 eat_len [N_PHILO];
  int                 expect_ids [$];  // whose eating rose, oldest first
  logic [SEQ_W-1:0]   seq_count;
  int                 full_run;        // cycles the log has sat full and stalled

  // a grant is legal for a hungry philosopher whose two forks are both free
  function automatic logic expected_grant(input int id, input logic [N_PHILO-1:0] was_hungry,
                                          input logic [N_PHILO-1:0] forks);
    return was_hungry[id] && !forks[id] && !forks[(id + 1) % N_PHILO];
  endfunction

  assign all_ate = &ate;

  always @(posedge clk) begin
    int  id;
    logic legal;
    if (reset) begin
      hungry_q   = '0;
      eating_q   = '0;
      fork_taken = '0;
      ate        = '0;
      seq_count  = '0;
      full_run   = 0;
      errors     = 0;
      pending    = 0;
      expect_ids.delete();
      for (int i = 0; i < N_PHILO; i++) eat_len[i] = 0;
    end else begin
      for (int i = 0; i < N_PHILO; i++) begin
        if (eating[i] && eating[(i + 1) % N_PHILO]) begin
          $display("Neighbours %0d and %0d are eating at the same time", i, (i + 1) % N_PHILO);
          errors++;
        end
      end
      if (expect_ids.size() >= FIFO_DEPTH && !log_ready) full_run++;
      else full_run = 0;
      for (int i = 0; i < N_PHILO; i++) begin
        if (eating[i] && !eating_q[i]) begin  // eating rose
          legal = expected_grant(i, hungry_q, fork_taken);
          if (legal !== 1'b1) begin
            $display("Error fork_rule: philosopher %0d, expected %0b, actual 1", i, legal);
            errors++;
          end
          if (full_run >= 3) begin
            $display("Philosopher %0d started eating while the grant log was full", i);
            errors++;
          end
          fork_taken[i]                 = 1'b1;
          fork_taken[(i + 1) % N_PHILO] = 1'b1;
          expect_ids.push_back(i);
          ate[i]     = 1'b1;
          eat_len[i] = 1;
        end else if (eating[i]) begin
          eat_len[i]++;
        end else if (eating_q[i]) begin  // eating fell
          if (eat_len[i] != EAT_TIME) begin
            $display("Error eat_length: philosopher %0d, expected %0d, actual %0d",
                     i, EAT_TIME, eat_len[i]);
            errors++;
          end
          fork_taken[i]                 = 1'b0;
          fork_taken[(i + 1) % N_PHILO] = 1'b0;
        end
      end
      if (log_valid && log_ready) begin  // record leaves the log
        if (expect_ids.size() == 0) begin
          $display("A grant record came out with no philosopher starting to eat");
          errors++;
        end else begin
          id = expect_ids.pop_front();
          if (int'(log_rec.philo_id) != id) begin
            $display("Error grant_log_id: expected %0d, actual %0d", id, log_rec.philo_id);
            errors++;
          end
        end
        if (log_rec.seq != seq_count) begin
          $display("Error grant_log_seq: expected %0d, actual %0d", seq_count, log_rec.seq);
          errors++;
        end
        seq_count++;
      end
      if (report_starve) begin
        for (int i = 0; i < N_PHILO; i++) begin
          if (!ate[i]) begin
            $display("Philosopher %0d never ate under full load", i);
            errors++;
          end
        end
      end
      if (arm_progress) ate = '0;
      hungry_q = hungry;
      eating_q = eating;
      pending  = expect_ids.size();
    end
  end

endmodule

//--- tb/table_sva.sv
`timescale 1ns/1ns

module table_sva #(
  parameter int N_PHILO = 4
) (
  input logic                clk,
  input logic                reset,
  input dpp_pkg::fork_e      forks [N_PHILO],
  input logic [N_PHILO-1:0]  granted,
  input logic [N_PHILO-1:0]  may_eat,
  input logic [N_PHILO-1:0]  evt_pop,
  input dpp_pkg::philo_evt_e evt_data [N_PHILO],
  input logic                log_push,
  input logic                log_full
);

  import dpp_pkg::*;

  int fail_count = 0;  // assertion failures so far

  for (genvar i = 0; i < N_PHILO; i++) begin : g_seat
    localparam int L = (i + N_PHILO - 1) % N_PHILO;  // other user of fork i
    localparam int R = (i + 1) % N_PHILO;

    // fork i is taken exactly when one of the two philosophers next to it holds it
    a_fork_owner: assert property (@(posedge clk) disable iff (reset)
      (forks[i] == FORK_TAKEN) == (granted[i] | granted[L]))
      else begin
        fail_count++;
        $error("fork %0d state disagrees with the granted philosophers", i);
      end

    // a grant goes out only while neither neighbour holds a shared fork
    a_may_eat_nbr: assert property (@(posedge clk) disable iff (reset)
      may_eat[i] |-> (!granted[L] && !granted[R]))
      else begin
        fail_count++;
        $error("may_eat raised for %0d while a neighbour holds a shared fork", i);
      end

    // a DONE only comes from a philosopher that holds its forks
    a_pop_done: assert property (@(posedge clk) disable iff (reset)
      (evt_pop[i] && evt_data[i] == PHILO_DONE) |-> granted[i])
      else begin
        fail_count++;
        $error("DONE popped for philosopher %0d that holds no forks", i);
      end
  end

  a_push_full: assert property (@(posedge clk) disable iff (reset)
    !(log_push && log_full))
    else begin
      fail_count++;
      $error("grant record pushed into a full log");
    end

endmodule

//--- tb/tb_dining_table.sv
`timescale 1ns/1ns

module tb_dining_table;

  import dpp_pkg::*;

  localparam int N_PHILO        = DEF_N_PHILO;
  localparam int EAT_TIME       = DEF_EAT_TIME;
  localparam int THINK_TIME     = DEF_THINK_TIME;
  localparam int FIFO_DEPTH     = DEF_FIFO_DEPTH;
  localparam int LIGHT_CYCLES   = 300;
  localparam int PROGRESS_LIMIT = 2000;
  localparam int STALL_CYCLES   = 50;
  localparam int DRAIN_LIMIT    = 300;

  logic               clk;
  logic               reset;
  logic [N_PHILO-1:0] hunger;
  logic               log_ready;
  logic [N_PHILO-1:0] hungry;
  logic [N_PHILO-1:0] eating;
  logic               log_valid;
  grant_rec_t         log_rec;
  logic               arm_progress;
  logic               report_starve;
  int                 check_errors;
  int                 pending;
  logic               all_ate;
  int                 timeouts;
  int                 sva_fails;
  logic [15:0]        lfsr;

  dining_table #(
    .N_PHILO    (N_PHILO),
    .EAT_TIME   (EAT_TIME),
    .THINK_TIME (THINK_TIME),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dining_table_i (
    .clk       (clk),
    .reset     (reset),
    .hunger    (hunger),
    .log_ready (log_ready),
    .hungry    (hungry),
    .eating    (eating),
    .log_valid (log_valid),
    .log_rec   (log_rec)
  );

  table_checker #(
    .N_PHILO    (N_PHILO),
    .EAT_TIME   (EAT_TIME),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) check_i (
    .clk           (clk),
    .reset         (reset),
    .hungry        (hungry),
    .eating        (eating),
    .log_valid     (log_valid),
    .log_ready     (log_ready),
    .log_rec       (log_rec),
    .arm_progress  (arm_progress),
    .report_starve (report_starve),
    .errors        (check_errors),
    .pending       (pending),
    .all_ate       (all_ate)
  );

  bind fork_arbiter table_sva #(
    .N_PHILO (N_PHILO)
  ) sva_i (
    .clk       (clk),
    .reset     (reset),
    .forks     (forks),
    .granted   (granted),
    .may_eat   (may_eat),
    .evt_pop   (evt_pop),
    .evt_data  (evt_data),
    .log_push  (log_push),
    .log_full  (log_full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic random_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  // high with odds 1 in 2**n
  function automatic logic biased_bit(input int n);
    logic b;
    b = 1'b1;
    for (int k = 0; k < n; k++) begin
      b = b & random_bit();
    end
    return b;
  endfunction

  task automatic drive_cycle(input int hunger_n, input int ready_n, input logic stall);
    @(negedge clk);
    for (int i = 0; i < N_PHILO; i++) begin
      hunger[i] = biased_bit(hunger_n);
    end
    log_ready = stall ? 1'b0 : biased_bit(ready_n);
  endtask

  task automatic drive_idle();
    @(negedge clk);
    hunger    = '0;
    log_ready = 1'b1;
  endtask

  initial begin
    int n;
    int quiet;
    reset         = 1'b1;
    hunger        = '0;
    log_ready     = 1'b0;
    arm_progress  = 1'b0;
    report_starve = 1'b0;
    timeouts      = 0;
    lfsr          = 16'd21288;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    $display("light load");
    for (n = 0; n < LIGHT_CYCLES; n++) drive_cycle(3, 1, 1'b0);

    $display("full load");
    arm_progress = 1'b1;  // opens the window in which everyone must eat
    drive_cycle(0, 1, 1'b0);
    arm_progress = 1'b0;
    n = 0;
    while (!all_ate && n < PROGRESS_LIMIT) begin
      drive_cycle(0, 1, 1'b0);
      n++;
    end
    if (!all_ate) begin
      $display("Timeout: not every philosopher ate under full load");
      timeouts++;
      report_starve = 1'b1;
      drive_cycle(0, 1, 1'b0);
      report_starve = 1'b0;
    end

    $display("log stalled");
    for (n = 0; n < STALL_CYCLES; n++) drive_cycle(1, 0, 1'b1);
    n     = 0;
    quiet = 0;
    while (quiet < 10 && n < DRAIN_LIMIT) begin
      drive_idle();
      if (!log_valid && eating == '0 && pending == 0) quiet++;
      else quiet = 0;
      n++;
    end
    if (quiet < 10) begin
      $display("Timeout: grant log did not drain after the stall");
      timeouts++;
    end

    sva_fails = dining_table_i.arbiter_i.sva_i.fail_count;
    $display("Done: %0d checker errors, %0d assertion failures, %0d timeouts",
             check_errors, sva_fails, timeouts);
    if (check_errors == 0 && sva_fails == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
